//--- sources.f
issue_pkg.sv
issue_decoder.sv
issue_scoreboard.sv
issue_select.sv
issue_top.sv
tb_clock_gen.sv
tb_issue.sv

//--- Bender.yml
package:
  name: issue_stage

sources:
  # design, package first
  - issue_pkg.sv
  - issue_decoder.sv
  - issue_scoreboard.sv
  - issue_select.sv
  - issue_top.sv
  # testbench
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_issue.sv

//--- tb_issue.sv
`default_nettype none

module tb_issue;

	localparam int SEED = 25310;
	localparam int RESET_CYCLES = 10;
	localparam int DIRECTED_CYCLES = 28;
	localparam int RAND_CYCLES = 2000;
	localparam int DRIVE_DELAY = 10;
	// run length plus some slack
	localparam int TIMEOUT = (RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES) * 100 + 2000;

	// opcode encodings from the table
	localparam logic [5:0] ADD  = issue_pkg::OP_ADD;
	localparam logic [5:0] ADDI = issue_pkg::OP_ADDI;
	localparam logic [5:0] LD   = issue_pkg::OP_LD;
	localparam logic [5:0] ST   = issue_pkg::OP_ST;
	localparam logic [5:0] BEQ  = issue_pkg::OP_BEQ;
	localparam logic [5:0] MUL  = issue_pkg::OP_MUL;
	localparam logic [31:0] NOP_WORD = 32'd0;

	// reference view of one decoded slot
	typedef struct packed {
		logic [4:0]      w;
		logic [1:0][4:0] r;
		// second operand needed only at m2
		logic            late;
		// result forwardable only at m2
		logic            slow;
		logic            p1;
		logic            p2;
	} ref_dec_t;

	logic clk;
	logic rst_n;
	issue_pkg::inst_word_u [1:0] inst_word;
	logic [1:0] inst_valid;
	issue_pkg::stage_vec_t [1:0] stall_vec;
	issue_pkg::stage_vec_t [1:0] clr_vec;
	logic stall_req;
	logic clr_fe;
	logic [1:0] issue;
	logic revert;
	issue_pkg::fwd_info_t [1:0][1:0] fwd_info;

	// reference scoreboard and predictions
	issue_pkg::sb_entry_t ref_sb [32];
	ref_dec_t dec [2];
	logic [1:0] exp_issue;
	logic exp_revert;
	issue_pkg::fwd_info_t [1:0][1:0] exp_fwd;

	tb_clock_gen u_clk (
		.clk_o (clk)
	);

	issue_top DUT (
		.clk            (clk),
		.rst_n          (rst_n),
		.inst_word_i    (inst_word),
		.inst_valid_i   (inst_valid),
		.stall_vec_i    (stall_vec),
		.clr_vec_i      (clr_vec),
		.stall_i        (stall_req),
		.clr_frontend_i (clr_fe),
		.issue_o        (issue),
		.revert_o       (revert),
		.fwd_info_o     (fwd_info)
	);

	task automatic stop_with_failure(input string line);
		$display("%s", line);
		$display("Checks failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] make_word(
		input logic [5:0] op,
		input logic [4:0] rd,
		input logic [4:0] rj,
		input logic [4:0] rk
	);
		return {op, rd, rj, rk, 11'd0};
	endfunction

	// mostly table opcodes over r0..r3, so conflicts are common
	function automatic logic [31:0] random_word();
		logic [5:0] op;
		op = 6'($urandom_range(0, 7));
		// slot 7 gives any opcode, mostly unknown ones
		if (op == 6'd7) begin
			op = 6'($urandom);
		end
		return {op, 5'($urandom_range(0, 3)), 5'($urandom_range(0, 3)),
			5'($urandom_range(0, 3)), 11'($urandom)};
	endfunction

	// each bit set with probability 1/one_in
	function automatic logic [5:0] random_stage_mask(input int one_in);
		logic [5:0] m;
		for (int b = 0; b < 6; b++) begin
			m[b] = ($urandom_range(0, one_in - 1) == 0);
		end
		return m;
	endfunction

	task automatic ref_decode();
		logic [31:0] w;
		logic [5:0] op;
		for (int s = 0; s < 2; s++) begin
			w = inst_word[s];
			op = w[31:26];
			dec[s] = '0;
			if (op inside {ADD, ADDI, LD, ST, BEQ, MUL}) begin
				dec[s].r[0] = w[20:16];
			end
			if (op inside {ADD, ADDI, LD, MUL}) begin
				dec[s].w = w[25:21];
			end
			if (op inside {ADD, MUL}) begin
				dec[s].r[1] = w[15:11];
			end
			// store data and branch compare come from rd
			if (op inside {ST, BEQ}) begin
				dec[s].r[1] = w[25:21];
			end
			dec[s].late = (op == ST);
			dec[s].slow = (op inside {LD, MUL});
			dec[s].p1 = (op inside {LD, ST, BEQ});
			dec[s].p2 = (op == MUL);
		end
	endtask

	// pending writer that cannot be forwarded in time
	function automatic logic ref_hazard(input issue_pkg::sb_entry_t e, input logic late);
		if (late) begin
			return (e.inst_pos != 3'b000) && (e.fwd_ready == 3'b000);
		end
		return (e.inst_pos != 3'b000) && !e.fwd_ready[0];
	endfunction

	task automatic predict();
		logic [1:0] haz;
		logic dep;
		issue_pkg::sb_entry_t e;
		ref_decode();
		for (int i = 0; i < 2; i++) begin
			haz[i] = ref_hazard(ref_sb[dec[i].r[0]], 1'b0) |
				ref_hazard(ref_sb[dec[i].r[1]], dec[i].late);
		end
		// slot 1 touching slot 0's destination
		dep = (dec[0].w != 5'd0) && ((dec[0].w == dec[1].r[0]) ||
			(dec[0].w == dec[1].r[1]) || (dec[0].w == dec[1].w));
		exp_issue[0] = inst_valid[0] && !haz[0] && !stall_req && !clr_fe;
		exp_issue[1] = exp_issue[0] && inst_valid[1] && !haz[1] && !dep &&
			!(dec[0].p1 && dec[1].p1);
		exp_revert = (exp_issue[1] && dec[1].p1) || (exp_issue[0] && dec[0].p2);
		for (int i = 0; i < 2; i++) begin
			for (int j = 0; j < 2; j++) begin
				e = ref_sb[dec[i].r[j]];
				exp_fwd[i][j] = '0;
				exp_fwd[i][j].fwd_pipe_sel = e.pipe_sel;
				// consumer in ex can take the writer from any stage
				for (int k = 0; k < 3; k++) begin
					exp_fwd[i][j].ex_src[k + 1] = e.inst_pos[k] & e.fwd_ready[0];
				end
				for (int k = 0; k < 2; k++) begin
					exp_fwd[i][j].m1_src[k + 1] = e.inst_pos[k] & e.fwd_ready[1];
				end
				exp_fwd[i][j].m2_src[1] = e.inst_pos[0] & e.fwd_ready[2];
				// regfile when no stage matches
				exp_fwd[i][j].ex_src[0] = (exp_fwd[i][j].ex_src[3:1] == 3'b000);
				exp_fwd[i][j].m1_src[0] = (exp_fwd[i][j].m1_src[2:1] == 2'b00);
				exp_fwd[i][j].m2_src[0] = !exp_fwd[i][j].m2_src[1];
			end
		end
	endtask

	// what the edge does to the scoreboard
	task automatic update_model();
		logic frz;
		logic clr;
		for (int e = 1; e < 32; e++) begin
			frz = |(ref_sb[e].inst_pos & stall_vec[ref_sb[e].pipe_sel]);
			clr = |(ref_sb[e].inst_pos & clr_vec[ref_sb[e].pipe_sel]);
			if (!frz) begin
				ref_sb[e].inst_pos = ref_sb[e].inst_pos << 1;
				ref_sb[e].fwd_ready = clr ? 3'b000 : ref_sb[e].fwd_ready >> 1;
			end
		end
		for (int s = 0; s < 2; s++) begin
			if (exp_issue[s] && (dec[s].w != 5'd0)) begin
				ref_sb[dec[s].w].pipe_sel = 1'(s) ^ exp_revert;
				ref_sb[dec[s].w].inst_pos = 3'b001;
				ref_sb[dec[s].w].fwd_ready = dec[s].slow ? 3'b100 : 3'b111;
			end
		end
	endtask

	task automatic check_outputs();
		assert (issue !== 2'b10)
			else stop_with_failure($sformatf("FAIL %0t: slot 1 issued alone", $time));
		assert (issue === exp_issue)
			else stop_with_failure($sformatf("FAIL %0t: issue_o %b, expected %b",
				$time, issue, exp_issue));
		assert (revert === exp_revert)
			else stop_with_failure($sformatf("FAIL %0t: revert_o %b, expected %b",
				$time, revert, exp_revert));
		assert (fwd_info === exp_fwd)
			else stop_with_failure($sformatf("FAIL %0t: fwd_info_o %h, expected %h",
				$time, fwd_info, exp_fwd));
	endtask

	// drive after the edge, check mid-cycle, then step the model
	task automatic step(
		input logic [31:0] w0,
		input logic [31:0] w1,
		input logic [1:0]  valid,
		input logic        st,
		input logic        cf,
		input logic [5:0]  stall_v,
		input logic [5:0]  clr_v
	);
		@(posedge clk);
		#DRIVE_DELAY;
		inst_word[0] = w0;
		inst_word[1] = w1;
		inst_valid = valid;
		stall_req = st;
		clr_fe = cf;
		stall_vec = stall_v;
		clr_vec = clr_v;
		@(negedge clk);
		predict();
		check_outputs();
		update_model();
	endtask

	initial begin
		#(TIMEOUT);
		stop_with_failure("watchdog timeout, the run did not finish in time");
	end

	initial begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		inst_word = '0;
		inst_valid = 2'b00;
		stall_vec = '0;
		clr_vec = '0;
		stall_req = 1'b0;
		clr_fe = 1'b0;
		for (int e = 0; e < 32; e++) begin
			ref_sb[e] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;

		// independent pair right after reset
		step(make_word(ADD, 1, 2, 3), make_word(ADD, 5, 6, 7), 2'b11, 0, 0, 0, 0);
		// load, then an ex-time use waits for readiness
		step(make_word(LD, 8, 1, 0), NOP_WORD, 2'b11, 0, 0, 0, 0);
		repeat (4) step(make_word(ADD, 9, 8, 8), NOP_WORD, 2'b01, 0, 0, 0, 0);
		// mul in slot 0 with load in slot 1 swaps pipes
		step(make_word(MUL, 10, 2, 3), make_word(LD, 11, 2, 0), 2'b11, 0, 0, 0, 0);
		repeat (3) step(make_word(ADD, 12, 10, 11), make_word(ST, 10, 11, 0), 2'b11,
			0, 0, 0, 0);
		// pair rules
		step(make_word(LD, 13, 1, 0), make_word(BEQ, 2, 1, 0), 2'b11, 0, 0, 0, 0);
		step(make_word(ADD, 14, 1, 2), make_word(ADD, 15, 14, 1), 2'b11, 0, 0, 0, 0);
		step(make_word(ADD, 16, 1, 2), make_word(ADDI, 16, 3, 0), 2'b11, 0, 0, 0, 0);
		// front end stall, then front end clear
		step(make_word(ADD, 17, 1, 2), make_word(ADD, 18, 1, 2), 2'b11, 1, 0, 0, 0);
		step(make_word(ADD, 17, 1, 2), make_word(ADD, 18, 1, 2), 2'b11, 0, 1, 0, 0);
		// load frozen in pipe 0 ex keeps its consumer blocked
		step(make_word(LD, 19, 1, 0), NOP_WORD, 2'b11, 0, 0, 0, 0);
		repeat (4) step(make_word(ADD, 20, 19, 1), NOP_WORD, 2'b01, 0, 0, 6'o01, 0);
		repeat (3) step(make_word(ADD, 20, 19, 1), NOP_WORD, 2'b01, 0, 0, 0, 0);
		// clear in pipe 0 ex drops the writer's readiness
		step(make_word(ADD, 21, 1, 2), NOP_WORD, 2'b01, 0, 0, 0, 0);
		step(make_word(ADD, 22, 21, 1), NOP_WORD, 2'b01, 0, 0, 0, 6'o01);
		repeat (3) step(make_word(ADD, 23, 21, 1), NOP_WORD, 2'b01, 0, 0, 0, 0);

		// long random run, valid pairs favored
		for (int c = 0; c < RAND_CYCLES; c++) begin
			step(random_word(), random_word(),
				($urandom_range(0, 3) == 0) ? 2'($urandom) : 2'b11,
				($urandom_range(0, 9) == 0), ($urandom_range(0, 19) == 0),
				random_stage_mask(8), random_stage_mask(12));
		end

		// any mismatch has already stopped the run
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
	output logic clk_o
);

	// period of 100
	localparam int HALF_PERIOD = 50;

	initial begin
		clk_o = 1'b0;
		forever begin
			#HALF_PERIOD;
			clk_o = ~clk_o;
		end
	end

endmodule

`default_nettype wire

//--- issue_top.sv
`default_nettype none

module issue_top (
	input  wire logic                           clk,
	input  wire logic                           rst_n,
	input  wire issue_pkg::inst_word_u    [1:0] inst_word_i,
	input  wire logic                     [1:0] inst_valid_i,
	// one stage vector per pipe
	input  wire issue_pkg::stage_vec_t    [1:0] stall_vec_i,
	input  wire issue_pkg::stage_vec_t    [1:0] clr_vec_i,
	input  wire logic                           stall_i,
	input  wire logic                           clr_frontend_i,
	// only 00, 01 or 11
	output logic                          [1:0] issue_o,
	// slot 0 to pipe 1 and slot 1 to pipe 0
	output logic                                revert_o,
	// indexed by slot then operand
	output issue_pkg::fwd_info_t     [1:0][1:0] fwd_info_o
);

	// decoded pair
	issue_pkg::inst_t [1:0] inst;

	// current scoreboard state
	issue_pkg::sb_entry_t [31:0] sb;

	issue_decoder u_decoder (
		.inst_word_i (inst_word_i),
		.inst_o      (inst)
	);

	// issue decision and forwarding from the current scoreboard
	issue_select u_select (
		.inst_valid_i   (inst_valid_i),
		.inst_i         (inst),
		.sb_i           (sb),
		.stall_i        (stall_i),
		.clr_frontend_i (clr_frontend_i),
		.issue_o        (issue_o),
		.revert_o       (revert_o),
		.fwd_info_o     (fwd_info_o)
	);

	// issued writers enter the scoreboard at the next edge
	issue_scoreboard u_scoreboard (
		.clk         (clk),
		.rst_n       (rst_n),
		.inst_i      (inst),
		.issue_i     (issue_o),
		.revert_i    (revert_o),
		.stall_vec_i (stall_vec_i),
		.clr_vec_i   (clr_vec_i),
		.sb_o        (sb)
	);

endmodule

`default_nettype wire

//--- issue_select.sv
`default_nettype none

module issue_select (
	input  wire logic                        [1:0] inst_valid_i,
	input  wire issue_pkg::inst_t            [1:0] inst_i,
	input  wire issue_pkg::sb_entry_t       [31:0] sb_i,
	input  wire logic                              stall_i,
	input  wire logic                              clr_frontend_i,
	output logic                             [1:0] issue_o,
	output logic                                   revert_o,
	output issue_pkg::fwd_info_t        [1:0][1:0] fwd_info_o
);

	// scoreboard entries of the four source operands
	issue_pkg::sb_entry_t [1:0][1:0] src_entry;

	// raw hazard per slot
	logic [1:0] hazard;

	logic front_hold;
	logic pair_data_conflict;
	logic pair_ctrl_conflict;
	logic issue_first;
	logic issue_second;

	// pending writer not yet forwardable in time
	function automatic logic operand_hazard(
		input issue_pkg::sb_entry_t entry,
		input issue_pkg::use_time_e use_time
	);
		logic pending;
		pending = |entry.inst_pos;
		if (use_time == issue_pkg::USE_EX) begin
			// must be ready by the time we reach ex
			return pending & ~entry.fwd_ready[0];
		end
		// late use, any readiness will catch up by m2
		return pending & ~|entry.fwd_ready;
	endfunction

	// writer stage masked by readiness, regfile when nothing matches
	function automatic issue_pkg::fwd_info_t fwd_encode(input issue_pkg::sb_entry_t entry);
		issue_pkg::fwd_info_t info;
		info.fwd_pipe_sel = entry.pipe_sel;
		// consumer in ex, writer anywhere in ex..m2
		info.ex_src[3:1] = entry.inst_pos & {3{entry.fwd_ready[0]}};
		info.ex_src[0]   = ~|info.ex_src[3:1];
		// consumer in m1, writer one stage behind at most
		info.m1_src[2:1] = entry.inst_pos[1:0] & {2{entry.fwd_ready[1]}};
		info.m1_src[0]   = ~|info.m1_src[2:1];
		// consumer in m2, writer still in ex
		info.m2_src[1]   = entry.inst_pos[0] & entry.fwd_ready[2];
		info.m2_src[0]   = ~info.m2_src[1];
		return info;
	endfunction

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			for (int j = 0; j < 2; j++) begin
				src_entry[i][j] = sb_i[inst_i[i].reg_info.r_reg[j]];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			hazard[i] =
				operand_hazard(src_entry[i][0], inst_i[i].decode_info.use_time[0]) |
				operand_hazard(src_entry[i][1], inst_i[i].decode_info.use_time[1]);
		end
	end

	assign front_hold = stall_i | clr_frontend_i;

	// second reads or rewrites the first one's destination
	// r0 as destination never conflicts
	assign pair_data_conflict = (inst_i[0].reg_info.w_reg != 5'd0) &&
		((inst_i[0].reg_info.w_reg == inst_i[1].reg_info.r_reg[0]) ||
		 (inst_i[0].reg_info.w_reg == inst_i[1].reg_info.r_reg[1]) ||
		 (inst_i[0].reg_info.w_reg == inst_i[1].reg_info.w_reg));

	// only one memory/branch op per pair
	assign pair_ctrl_conflict = inst_i[0].decode_info.pipe_one_inst &
		inst_i[1].decode_info.pipe_one_inst;

	assign issue_first = inst_valid_i[0] & ~hazard[0] & ~front_hold;

	// in order, so slot 1 never goes alone
	assign issue_second = issue_first & inst_valid_i[1] & ~hazard[1] &
		~pair_data_conflict & ~pair_ctrl_conflict;

	assign issue_o = {issue_second, issue_first};

	// swap when slot 1 needs pipe 0 or slot 0 needs pipe 1
	assign revert_o = (issue_second & inst_i[1].decode_info.pipe_one_inst) |
		(issue_first & inst_i[0].decode_info.pipe_two_inst);

	for (genvar i = 0; i < 2; i++) begin : g_fwd_inst
		for (genvar j = 0; j < 2; j++) begin : g_fwd_opnd
			assign fwd_info_o[i][j] = fwd_encode(src_entry[i][j]);
		end
	end

endmodule

`default_nettype wire

//--- issue_scoreboard.sv
`default_nettype none

module issue_scoreboard (
	input  wire logic                           clk,
	input  wire logic                           rst_n,
	input  wire issue_pkg::inst_t         [1:0] inst_i,
	input  wire logic                     [1:0] issue_i,
	input  wire logic                           revert_i,
	input  wire issue_pkg::stage_vec_t    [1:0] stall_vec_i,
	input  wire issue_pkg::stage_vec_t    [1:0] clr_vec_i,
	output issue_pkg::sb_entry_t         [31:0] sb_o
);

	// one entry per architectural register
	issue_pkg::sb_entry_t [31:0] sb_q;
	issue_pkg::sb_entry_t [31:0] sb_d;

	// per entry, does its stage in its pipe stall or clear
	logic [31:0] entry_stall;
	logic [31:0] entry_clr;

	always_comb begin
		for (int e = 0; e < 32; e++) begin
			entry_stall[e] = |(sb_q[e].inst_pos & stall_vec_i[sb_q[e].pipe_sel]);
			entry_clr[e]   = |(sb_q[e].inst_pos & clr_vec_i[sb_q[e].pipe_sel]);
		end
	end

	always_comb begin
		for (int e = 0; e < 32; e++) begin
			// normal advance
			// position moves up one stage, readiness moves toward ex
			sb_d[e].pipe_sel  = sb_q[e].pipe_sel;
			sb_d[e].inst_pos  = {sb_q[e].inst_pos[1:0], 1'b0};
			sb_d[e].fwd_ready = {1'b0, sb_q[e].fwd_ready[2:1]};

			// cleared stage still advances but never forwards
			if (entry_clr[e]) begin
				sb_d[e].fwd_ready = 3'b000;
			end

			// stall wins over clear
			if (entry_stall[e]) begin
				sb_d[e].inst_pos  = sb_q[e].inst_pos;
				sb_d[e].fwd_ready = sb_q[e].fwd_ready;
			end

			// a newly issued writer overrides everything
			for (int s = 0; s < 2; s++) begin
				if (issue_i[s] && (inst_i[s].reg_info.w_reg == 5'(e))) begin
					// slot index swapped when the pair is reverted
					sb_d[e].pipe_sel = 1'(s) ^ revert_i;
					sb_d[e].inst_pos = 3'b001;
					// m2 always ready, m1 and ex only for single-cycle results
					sb_d[e].fwd_ready[2] = 1'b1;
					sb_d[e].fwd_ready[1] =
						(inst_i[s].decode_info.ready_time == issue_pkg::READY_EX);
					sb_d[e].fwd_ready[0] =
						(inst_i[s].decode_info.ready_time == issue_pkg::READY_EX);
				end
			end

			// r0 never has a pending writer
			if (e == 0) begin
				sb_d[e] = '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sb_q <= '0;
		end else begin
			sb_q <= sb_d;
		end
	end

	assign sb_o = sb_q;

endmodule

`default_nettype wire

//--- issue_decoder.sv
`default_nettype none

module issue_decoder (
	input  wire issue_pkg::inst_word_u [1:0] inst_word_i,
	output issue_pkg::inst_t          [1:0] inst_o
);

	// table attributes per slot
	issue_pkg::op_attr_t [1:0] attr;

	// register fields taken from the matching view
	logic [1:0][4:0] rd_field;
	logic [1:0][4:0] rj_field;
	logic [1:0][4:0] rk_field;

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			// opcode position shared by both views
			attr[i] = issue_pkg::op_lookup(inst_word_i[i].rr.opcode);

			// rd and rj sit in the same bits in both views
			rd_field[i] = inst_word_i[i].ri.rd;
			rj_field[i] = inst_word_i[i].ri.rj;

			if (attr[i].ri_fmt) begin
				// immediate format has no rk
				rk_field[i] = 5'd0;
			end else begin
				rk_field[i] = inst_word_i[i].rr.rk;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			// destination only for writers
			if (attr[i].wr_rd) begin
				inst_o[i].reg_info.w_reg = rd_field[i];
			end else begin
				inst_o[i].reg_info.w_reg = 5'd0;
			end

			// first source is always rj when used
			if (attr[i].src0_rj) begin
				inst_o[i].reg_info.r_reg[0] = rj_field[i];
			end else begin
				inst_o[i].reg_info.r_reg[0] = 5'd0;
			end

			// second source from rk, or rd for store and branch
			if (attr[i].src1_rk) begin
				inst_o[i].reg_info.r_reg[1] = rk_field[i];
			end else if (attr[i].src1_rd) begin
				inst_o[i].reg_info.r_reg[1] = rd_field[i];
			end else begin
				inst_o[i].reg_info.r_reg[1] = 5'd0;
			end

			// unused sources point at r0 so timing is irrelevant
			inst_o[i].decode_info.use_time[0] = issue_pkg::USE_EX;
			if (attr[i].src1_m2) begin
				inst_o[i].decode_info.use_time[1] = issue_pkg::USE_M2;
			end else begin
				inst_o[i].decode_info.use_time[1] = issue_pkg::USE_EX;
			end

			inst_o[i].decode_info.ready_time    = attr[i].ready_time;
			inst_o[i].decode_info.pipe_one_inst = attr[i].pipe_one;
			inst_o[i].decode_info.pipe_two_inst = attr[i].pipe_two;
		end
	end

endmodule

`default_nettype wire

//--- issue_pkg.sv
`default_nettype none

package issue_pkg;

	// invented opcode table encodings
	typedef enum logic [5:0] {
		OP_NOP  = 6'h00,
		OP_ADD  = 6'h01,
		OP_ADDI = 6'h02,
		OP_LD   = 6'h03,
		OP_ST   = 6'h04,
		OP_BEQ  = 6'h05,
		OP_MUL  = 6'h06
	} opcode_e;

	// register-register layout
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rd;
		logic [4:0]  rj;
		logic [4:0]  rk;
		logic [10:0] funct;
	} inst_rr_t;

	// register-immediate layout
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rd;
		logic [4:0]  rj;
		logic [15:0] imm;
	} inst_ri_t;

	// opcode sits in the same bits in both views
	typedef union packed {
		inst_rr_t rr;
		inst_ri_t ri;
	} inst_word_u;

	// stage by which a source must be available
	typedef enum logic {
		USE_EX = 1'b0,
		USE_M2 = 1'b1
	} use_time_e;

	// stage at whose end the result can be forwarded
	typedef enum logic {
		READY_EX = 1'b0,
		READY_M2 = 1'b1
	} ready_time_e;

	typedef struct packed {
		logic [4:0]      w_reg;
		logic [1:0][4:0] r_reg;
	} reg_info_t;

	typedef struct packed {
		use_time_e [1:0] use_time;
		ready_time_e     ready_time;
		// load, store, branch
		logic            pipe_one_inst;
		// multiply
		logic            pipe_two_inst;
	} decode_info_t;

	typedef struct packed {
		reg_info_t    reg_info;
		decode_info_t decode_info;
	} inst_t;

	// bit 0 ex, bit 1 m1, bit 2 m2
	typedef logic [2:0] stage_vec_t;

	typedef struct packed {
		logic       pipe_sel;
		// one-hot, moves toward m2
		logic [2:0] inst_pos;
		// moves toward the ex bit
		logic [2:0] fwd_ready;
	} sb_entry_t;

	typedef struct packed {
		logic       fwd_pipe_sel;
		// bit 0 regfile, bits 3:1 writer at ex/m1/m2
		logic [3:0] ex_src;
		logic [2:0] m1_src;
		logic [1:0] m2_src;
	} fwd_info_t;

	// per-opcode attributes
	typedef struct packed {
		logic        ri_fmt;
		logic        wr_rd;
		logic        src0_rj;
		logic        src1_rk;
		logic        src1_rd;
		logic        src1_m2;
		ready_time_e ready_time;
		logic        pipe_one;
		logic        pipe_two;
	} op_attr_t;

	function automatic op_attr_t op_lookup(input logic [5:0] op);
		op_attr_t attr;
		attr = '0;
		case (op)
			OP_ADD: begin
				attr.wr_rd = 1'b1;
				attr.src0_rj = 1'b1;
				attr.src1_rk = 1'b1;
			end
			OP_ADDI: begin
				attr.ri_fmt = 1'b1;
				attr.wr_rd = 1'b1;
				attr.src0_rj = 1'b1;
			end
			OP_LD: begin
				attr.ri_fmt = 1'b1;
				attr.wr_rd = 1'b1;
				attr.src0_rj = 1'b1;
				attr.ready_time = READY_M2;
				attr.pipe_one = 1'b1;
			end
			OP_ST: begin
				// store data in rd, needed late
				attr.ri_fmt = 1'b1;
				attr.src0_rj = 1'b1;
				attr.src1_rd = 1'b1;
				attr.src1_m2 = 1'b1;
				attr.pipe_one = 1'b1;
			end
			OP_BEQ: begin
				attr.ri_fmt = 1'b1;
				attr.src0_rj = 1'b1;
				attr.src1_rd = 1'b1;
				attr.pipe_one = 1'b1;
			end
			OP_MUL: begin
				attr.wr_rd = 1'b1;
				attr.src0_rj = 1'b1;
				attr.src1_rk = 1'b1;
				attr.ready_time = READY_M2;
				attr.pipe_two = 1'b1;
			end
			// nop and unknown opcodes touch no register
			default: attr = '0;
		endcase
		return attr;
	endfunction

endpackage

`default_nettype wire
